//--- flist.f
llc_pkg.sv
llc_spill_reg.sv
llc_hit_miss.sv
llc_miss_unit.sv
llc_data_ways.sv
llc_access_unit.sv
llc_top.sv
tb_llc.sv

//--- llc_access_unit.sv
/*
 * does the single word access of hit and refilled descriptors
 * hits take precedence, one descriptor is handled at a time
 * writes answer with zero rdata
 */
`timescale 1ns/1ps
`default_nettype none

module llc_access_unit (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               hit_valid_i,
  output logic               hit_ready_o,
  input  llc_pkg::llc_desc_t hit_desc_i,
  input  logic               refill_valid_i,
  output logic               refill_ready_o,
  input  llc_pkg::llc_desc_t refill_desc_i,
  output logic               au_req_valid_o,
  input  logic               au_req_ready_i,
  output logic               au_we_o,
  output llc_pkg::way_ind_t  au_way_ind_o,
  output llc_pkg::index_t    au_index_o,
  output llc_pkg::blk_t      au_blk_o,
  output llc_pkg::data_t     au_wdata_o,
  output llc_pkg::strb_t     au_strb_o,
  input  logic               au_rvalid_i,
  input  llc_pkg::data_t     au_rdata_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output llc_pkg::data_t     rsp_rdata_o,
  output logic               retire_o,
  output logic               retire_from_miss_o
);
  import llc_pkg::*;

  typedef enum logic [1:0] {Idle, Access, ReadWait, Respond} state_e;

  state_e    state_q;
  llc_desc_t desc_q;
  data_t     rdata_q;
  logic      take_hit, take_refill;

  assign hit_ready_o    = (state_q == Idle);
  assign refill_ready_o = (state_q == Idle) && !hit_valid_i;
  assign take_hit       = hit_valid_i && hit_ready_o;
  assign take_refill    = refill_valid_i && refill_ready_o;

  assign au_req_valid_o = (state_q == Access);
  assign au_we_o        = desc_q.write;
  assign au_way_ind_o   = desc_q.way_ind;
  assign au_index_o     = desc_q.addr[ByteOffsetLength+BlockOffsetLength +: IndexLength];
  assign au_blk_o       = desc_q.addr[ByteOffsetLength +: BlockOffsetLength];
  assign au_wdata_o     = desc_q.wdata;
  assign au_strb_o      = desc_q.strb;

  assign rsp_valid_o        = (state_q == Respond);
  assign rsp_rdata_o        = rdata_q;
  assign retire_o           = rsp_valid_o && rsp_ready_i;   // tells hit/miss the slot is free
  assign retire_from_miss_o = desc_q.from_miss;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
    end else begin
      unique case (state_q)
        Idle: if (take_hit || take_refill) state_q <= Access;
        Access: if (au_req_ready_i) state_q <= desc_q.write ? Respond : ReadWait;
        ReadWait: if (au_rvalid_i) state_q <= Respond;
        Respond: if (rsp_ready_i) state_q <= Idle;
        default: state_q <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_hit || take_refill) begin
      desc_q <= take_hit ? hit_desc_i : refill_desc_i;
    end
    if (au_req_valid_o && au_req_ready_i && desc_q.write) begin
      rdata_q <= '0;
    end else if (au_rvalid_i) begin
      rdata_q <= au_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- llc_data_ways.sv
/*
 * single-port data array shared by the miss unit and the access unit
 * miss unit has fixed priority, read data arrives one cycle after the grant
 */
`timescale 1ns/1ps
`default_nettype none

module llc_data_ways (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              mu_req_valid_i,
  output logic              mu_req_ready_o,
  input  logic              mu_we_i,
  input  llc_pkg::way_ind_t mu_way_ind_i,
  input  llc_pkg::index_t   mu_index_i,
  input  llc_pkg::blk_t     mu_blk_i,
  input  llc_pkg::data_t    mu_wdata_i,
  input  llc_pkg::strb_t    mu_strb_i,
  output logic              mu_rvalid_o,
  output llc_pkg::data_t    mu_rdata_o,
  input  logic              au_req_valid_i,
  output logic              au_req_ready_o,
  input  logic              au_we_i,
  input  llc_pkg::way_ind_t au_way_ind_i,
  input  llc_pkg::index_t   au_index_i,
  input  llc_pkg::blk_t     au_blk_i,
  input  llc_pkg::data_t    au_wdata_i,
  input  llc_pkg::strb_t    au_strb_i,
  output logic              au_rvalid_o,
  output llc_pkg::data_t    au_rdata_o
);
  import llc_pkg::*;

  data_t mem_q [NoWays][NoLines][NoBlocks];

  logic                   access, we;
  logic [WayIdxWidth-1:0] way;
  way_ind_t               way_ind;
  index_t                 idx;
  blk_t                   blk;
  data_t                  wdata, rdata_q;
  strb_t                  strb;
  logic                   mu_rvalid_q, au_rvalid_q;

  assign mu_req_ready_o = 1'b1;
  assign au_req_ready_o = !mu_req_valid_i;
  assign access  = mu_req_valid_i || au_req_valid_i;
  assign we      = mu_req_valid_i ? mu_we_i      : au_we_i;
  assign way_ind = mu_req_valid_i ? mu_way_ind_i : au_way_ind_i;
  assign idx     = mu_req_valid_i ? mu_index_i   : au_index_i;
  assign blk     = mu_req_valid_i ? mu_blk_i     : au_blk_i;
  assign wdata   = mu_req_valid_i ? mu_wdata_i   : au_wdata_i;
  assign strb    = mu_req_valid_i ? mu_strb_i    : au_strb_i;

  always_comb begin
    way = '0;
    for (int unsigned w = 0; w < NoWays; w++) begin
      if (way_ind[w]) begin
        way = WayIdxWidth'(w);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && we) begin
      for (int unsigned b = 0; b < StrbWidth; b++) begin
        if (strb[b]) begin
          mem_q[way][idx][blk][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
    if (access && !we) begin
      rdata_q <= mem_q[way][idx][blk];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mu_rvalid_q <= 1'b0;
      au_rvalid_q <= 1'b0;
    end else begin
      mu_rvalid_q <= mu_req_valid_i && !mu_we_i;
      au_rvalid_q <= au_req_valid_i && au_req_ready_o && !au_we_i;
    end
  end

  assign mu_rvalid_o = mu_rvalid_q;
  assign mu_rdata_o  = rdata_q;   // one read per cycle, so both share the register
  assign au_rvalid_o = au_rvalid_q;
  assign au_rdata_o  = rdata_q;

endmodule

`default_nettype wire

//--- llc_hit_miss.sv
/*
 * tag store with hit detection and round robin victim choice per line
 * only one miss is outstanding, and a miss leaves only with no hits in flight
 */
`timescale 1ns/1ps
`default_nettype none

module llc_hit_miss (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  llc_pkg::req_t      req_i,
  output logic               hit_valid_o,
  input  logic               hit_ready_i,
  output logic               miss_valid_o,
  input  logic               miss_ready_i,
  output llc_pkg::llc_desc_t desc_o,
  input  logic               retire_i,
  input  logic               retire_from_miss_i
);
  import llc_pkg::*;

  req_t                   req_q;        // request under lookup
  logic                   stage_q;
  logic                   miss_out_q;
  logic [HitCntWidth-1:0] hit_cnt_q;

  tag_t                   tag_q   [NoLines][NoWays];
  way_ind_t               valid_q [NoLines];
  way_ind_t               dirty_q [NoLines];
  logic [WayIdxWidth-1:0] rr_q    [NoLines];   // next victim

  tag_t     tag;
  index_t   idx;
  way_ind_t hit_way, victim;
  logic     hit, hit_xfer, miss_xfer;

  assign tag    = req_q.addr[AddrWidth-1 -: TagLength];
  assign idx    = req_q.addr[ByteOffsetLength+BlockOffsetLength +: IndexLength];
  assign victim = way_ind_t'(1) << rr_q[idx];

  always_comb begin
    for (int unsigned w = 0; w < NoWays; w++) begin
      hit_way[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
    end
  end
  assign hit = |hit_way;

  assign hit_valid_o  = stage_q && hit;
  assign miss_valid_o = stage_q && !hit && (hit_cnt_q == '0);
  assign hit_xfer     = hit_valid_o && hit_ready_i;
  assign miss_xfer    = miss_valid_o && miss_ready_i;
  // a miss leaving the stage keeps the next request out until it retires
  assign req_ready_o  = !miss_out_q && (!stage_q || hit_xfer);

  always_comb begin
    desc_o           = '0;
    desc_o.write     = req_q.write;
    desc_o.addr      = req_q.addr;
    desc_o.wdata     = req_q.wdata;
    desc_o.strb      = req_q.strb;
    desc_o.way_ind   = hit ? hit_way : victim;
    desc_o.evict     = |(victim & valid_q[idx] & dirty_q[idx]);
    desc_o.evict_tag = tag_q[idx][rr_q[idx]];
    desc_o.refill    = !hit;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_q    <= 1'b0;
      miss_out_q <= 1'b0;
      hit_cnt_q  <= '0;
      for (int unsigned l = 0; l < NoLines; l++) begin
        valid_q[l] <= '0;
        dirty_q[l] <= '0;
        rr_q[l]    <= '0;
      end
    end else begin
      if (req_valid_i && req_ready_o) begin
        stage_q <= 1'b1;
      end else if (hit_xfer || miss_xfer) begin
        stage_q <= 1'b0;
      end
      if (miss_xfer) begin
        miss_out_q <= 1'b1;
      end else if (retire_i && retire_from_miss_i) begin
        miss_out_q <= 1'b0;
      end
      hit_cnt_q <= hit_cnt_q + HitCntWidth'(hit_xfer)
                 - HitCntWidth'(retire_i && !retire_from_miss_i);
      if (hit_xfer && req_q.write) begin
        dirty_q[idx] <= dirty_q[idx] | hit_way;
      end
      if (miss_xfer) begin   // install the new line in the victim way
        valid_q[idx] <= valid_q[idx] | victim;
        dirty_q[idx] <= req_q.write ? (dirty_q[idx] | victim) : (dirty_q[idx] & ~victim);
        rr_q[idx]    <= (rr_q[idx] == WayIdxWidth'(NoWays - 1)) ? '0 : rr_q[idx] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
    if (miss_xfer) begin
      tag_q[idx][rr_q[idx]] <= tag;
    end
  end

endmodule

`default_nettype wire

//--- llc_miss_unit.sv
/*
 * one miss at a time: write back a dirty victim word by word, then refill
 * memory must return exactly NoBlocks read beats per line request
 */
`timescale 1ns/1ps
`default_nettype none

module llc_miss_unit (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               desc_valid_i,
  output logic               desc_ready_o,
  input  llc_pkg::llc_desc_t desc_i,
  output logic               desc_valid_o,
  input  logic               desc_ready_i,
  output llc_pkg::llc_desc_t desc_o,
  output logic               way_req_valid_o,
  input  logic               way_req_ready_i,
  output logic               way_we_o,
  output llc_pkg::way_ind_t  way_ind_o,
  output llc_pkg::index_t    way_index_o,
  output llc_pkg::blk_t      way_blk_o,
  output llc_pkg::data_t     way_wdata_o,
  output llc_pkg::strb_t     way_strb_o,
  input  logic               way_rvalid_i,
  input  llc_pkg::data_t     way_rdata_i,
  output logic               mem_w_valid_o,
  input  logic               mem_w_ready_i,
  output llc_pkg::addr_t     mem_w_addr_o,
  output llc_pkg::data_t     mem_w_data_o,
  output logic               mem_ar_valid_o,
  input  logic               mem_ar_ready_i,
  output llc_pkg::addr_t     mem_ar_addr_o,
  input  logic               mem_r_valid_i,
  output logic               mem_r_ready_o,
  input  llc_pkg::data_t     mem_r_data_i
);
  import llc_pkg::*;

  typedef enum logic [2:0] {Idle, EvictRd, EvictWait, EvictWr, LineRd, Refill, Done} state_e;

  state_e    state_q;
  llc_desc_t desc_q;
  blk_t      cnt_q;          // word within the line
  data_t     evict_data_q;
  index_t    idx;
  logic      last;

  assign idx  = desc_q.addr[ByteOffsetLength+BlockOffsetLength +: IndexLength];
  assign last = (cnt_q == blk_t'(NoBlocks - 1));

  assign desc_ready_o = (state_q == Idle);
  assign desc_valid_o = (state_q == Done);
  assign desc_o       = desc_q;

  // refill beats go straight into the way, the miss unit always gets the array
  assign way_req_valid_o = (state_q == EvictRd) || ((state_q == Refill) && mem_r_valid_i);
  assign way_we_o        = (state_q == Refill);
  assign way_ind_o       = desc_q.way_ind;
  assign way_index_o     = idx;
  assign way_blk_o       = cnt_q;
  assign way_wdata_o     = mem_r_data_i;
  assign way_strb_o      = '1;

  assign mem_w_valid_o  = (state_q == EvictWr);
  assign mem_w_addr_o   = {desc_q.evict_tag, idx, cnt_q, {ByteOffsetLength{1'b0}}};
  assign mem_w_data_o   = evict_data_q;
  assign mem_ar_valid_o = (state_q == LineRd);
  assign mem_ar_addr_o  = {desc_q.addr[AddrWidth-1 -: TagLength], idx,
                           {(BlockOffsetLength + ByteOffsetLength){1'b0}}};
  assign mem_r_ready_o  = (state_q == Refill) && way_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        Idle: if (desc_valid_i) begin
          cnt_q   <= '0;
          state_q <= desc_i.evict ? EvictRd : (desc_i.refill ? LineRd : Done);
        end
        EvictRd: if (way_req_ready_i) state_q <= EvictWait;
        EvictWait: if (way_rvalid_i) state_q <= EvictWr;
        EvictWr: if (mem_w_ready_i) begin
          cnt_q   <= cnt_q + 1'b1;   // wraps to zero for the refill
          state_q <= last ? (desc_q.refill ? LineRd : Done) : EvictRd;
        end
        LineRd: if (mem_ar_ready_i) state_q <= Refill;
        Refill: if (mem_r_valid_i && mem_r_ready_o) begin
          cnt_q <= cnt_q + 1'b1;
          if (last) begin
            state_q <= Done;
          end
        end
        Done: if (desc_ready_i) state_q <= Idle;
        default: state_q <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_valid_i && desc_ready_o) begin
      desc_q           <= desc_i;
      desc_q.from_miss <= 1'b1;
    end
    if (way_rvalid_i) begin
      evict_data_q <= way_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- llc_pkg.sv
/*
 * cache geometry and the types shared by all units
 * byte address is split as {tag, index, block offset, byte offset}
 * NoWays, NoLines and NoBlocks must be powers of two
 */
`default_nettype none

package llc_pkg;

  localparam int unsigned NoWays    = 2;
  localparam int unsigned NoLines   = 16;   // lines per way
  localparam int unsigned NoBlocks  = 4;    // words per line
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 16;   // byte address

  localparam int unsigned StrbWidth         = DataWidth / 8;
  localparam int unsigned ByteOffsetLength  = $clog2(StrbWidth);
  localparam int unsigned BlockOffsetLength = $clog2(NoBlocks);
  localparam int unsigned IndexLength       = $clog2(NoLines);
  localparam int unsigned TagLength         =
    AddrWidth - IndexLength - BlockOffsetLength - ByteOffsetLength;

  localparam int unsigned WayIdxWidth = (NoWays > 1) ? $clog2(NoWays) : 1;
  // hits in flight: two hit spill entries plus the one in the access unit
  localparam int unsigned HitCntWidth = 3;

  typedef logic [AddrWidth-1:0]         addr_t;
  typedef logic [DataWidth-1:0]         data_t;
  typedef logic [StrbWidth-1:0]         strb_t;
  typedef logic [TagLength-1:0]         tag_t;
  typedef logic [IndexLength-1:0]       index_t;
  typedef logic [BlockOffsetLength-1:0] blk_t;
  typedef logic [NoWays-1:0]            way_ind_t;   // one-hot

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } req_t;

  typedef struct packed {
    logic     write;
    addr_t    addr;
    data_t    wdata;
    strb_t    strb;
    way_ind_t way_ind;     // way the word lives in
    logic     evict;       // victim is dirty, write it back first
    tag_t     evict_tag;
    logic     refill;      // fetch the line from memory
    logic     from_miss;   // set by the miss unit
  } llc_desc_t;

endpackage

`default_nettype wire

//--- llc_spill_reg.sv
/*
 * two-entry valid/ready register slice
 * ready_o comes from flops only, so there is no combinational path back
 */
`timescale 1ns/1ps
`default_nettype none

module llc_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  T     a_data_q, b_data_q;
  logic a_full_q, b_full_q;
  logic a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;   // a leaves, either out or into b
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;   // b always holds the older entry

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

endmodule

`default_nettype wire

//--- llc_top.sv
/*
 * write-back cache between one word requester and one memory port
 * responses come back in request order, memory writes complete on handshake
 */
`timescale 1ns/1ps
`default_nettype none

module llc_top (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           req_valid_i,
  output logic           req_ready_o,
  input  logic           req_write_i,
  input  llc_pkg::addr_t req_addr_i,
  input  llc_pkg::data_t req_wdata_i,
  input  llc_pkg::strb_t req_strb_i,
  output logic           rsp_valid_o,
  input  logic           rsp_ready_i,
  output llc_pkg::data_t rsp_rdata_o,
  output logic           mem_w_valid_o,
  input  logic           mem_w_ready_i,
  output llc_pkg::addr_t mem_w_addr_o,
  output llc_pkg::data_t mem_w_data_o,
  output logic           mem_ar_valid_o,
  input  logic           mem_ar_ready_i,
  output llc_pkg::addr_t mem_ar_addr_o,
  input  logic           mem_r_valid_i,
  output logic           mem_r_ready_o,
  input  llc_pkg::data_t mem_r_data_i
);
  import llc_pkg::*;

  req_t      req_in, req_spill;
  logic      spill_valid, spill_ready;
  llc_desc_t hm_desc, hit_desc, refill_desc;
  logic      hm_hit_valid, hm_hit_ready, miss_valid, miss_ready;
  logic      hit_valid, hit_ready, refill_valid, refill_ready;
  logic      retire, retire_from_miss;

  // data way links, mu_ from the miss unit and au_ from the access unit
  logic      mu_req_valid, mu_req_ready, mu_we, mu_rvalid;
  way_ind_t  mu_way_ind;
  index_t    mu_index;
  blk_t      mu_blk;
  data_t     mu_wdata, mu_rdata;
  strb_t     mu_strb;
  logic      au_req_valid, au_req_ready, au_we, au_rvalid;
  way_ind_t  au_way_ind;
  index_t    au_index;
  blk_t      au_blk;
  data_t     au_wdata, au_rdata;
  strb_t     au_strb;

  assign req_in = '{write: req_write_i, addr: req_addr_i, wdata: req_wdata_i, strb: req_strb_i};

  llc_spill_reg #(.T(req_t)) i_req_spill (
    .clk_i, .rst_n_i,
    .valid_i (req_valid_i), .ready_o (req_ready_o), .data_i (req_in),
    .valid_o (spill_valid), .ready_i (spill_ready), .data_o (req_spill)
  );

  llc_hit_miss i_hit_miss (
    .clk_i, .rst_n_i,
    .req_valid_i  (spill_valid), .req_ready_o (spill_ready), .req_i (req_spill),
    .hit_valid_o  (hm_hit_valid), .hit_ready_i (hm_hit_ready),
    .miss_valid_o (miss_valid), .miss_ready_i (miss_ready), .desc_o (hm_desc),
    .retire_i (retire), .retire_from_miss_i (retire_from_miss)
  );

  // cuts the path from the access unit back into the tag lookup
  llc_spill_reg #(.T(llc_desc_t)) i_hit_spill (
    .clk_i, .rst_n_i,
    .valid_i (hm_hit_valid), .ready_o (hm_hit_ready), .data_i (hm_desc),
    .valid_o (hit_valid), .ready_i (hit_ready), .data_o (hit_desc)
  );

  llc_miss_unit i_miss_unit (
    .clk_i, .rst_n_i,
    .desc_valid_i (miss_valid), .desc_ready_o (miss_ready), .desc_i (hm_desc),
    .desc_valid_o (refill_valid), .desc_ready_i (refill_ready), .desc_o (refill_desc),
    .way_req_valid_o (mu_req_valid), .way_req_ready_i (mu_req_ready), .way_we_o (mu_we),
    .way_ind_o (mu_way_ind), .way_index_o (mu_index), .way_blk_o (mu_blk),
    .way_wdata_o (mu_wdata), .way_strb_o (mu_strb),
    .way_rvalid_i (mu_rvalid), .way_rdata_i (mu_rdata),
    .mem_w_valid_o, .mem_w_ready_i, .mem_w_addr_o, .mem_w_data_o,
    .mem_ar_valid_o, .mem_ar_ready_i, .mem_ar_addr_o,
    .mem_r_valid_i, .mem_r_ready_o, .mem_r_data_i
  );

  llc_data_ways i_data_ways (
    .clk_i, .rst_n_i,
    .mu_req_valid_i (mu_req_valid), .mu_req_ready_o (mu_req_ready), .mu_we_i (mu_we),
    .mu_way_ind_i (mu_way_ind), .mu_index_i (mu_index), .mu_blk_i (mu_blk),
    .mu_wdata_i (mu_wdata), .mu_strb_i (mu_strb),
    .mu_rvalid_o (mu_rvalid), .mu_rdata_o (mu_rdata),
    .au_req_valid_i (au_req_valid), .au_req_ready_o (au_req_ready), .au_we_i (au_we),
    .au_way_ind_i (au_way_ind), .au_index_i (au_index), .au_blk_i (au_blk),
    .au_wdata_i (au_wdata), .au_strb_i (au_strb),
    .au_rvalid_o (au_rvalid), .au_rdata_o (au_rdata)
  );

  llc_access_unit i_access_unit (
    .clk_i, .rst_n_i,
    .hit_valid_i (hit_valid), .hit_ready_o (hit_ready), .hit_desc_i (hit_desc),
    .refill_valid_i (refill_valid), .refill_ready_o (refill_ready),
    .refill_desc_i (refill_desc),
    .au_req_valid_o (au_req_valid), .au_req_ready_i (au_req_ready), .au_we_o (au_we),
    .au_way_ind_o (au_way_ind), .au_index_o (au_index), .au_blk_o (au_blk),
    .au_wdata_o (au_wdata), .au_strb_o (au_strb),
    .au_rvalid_i (au_rvalid), .au_rdata_i (au_rdata),
    .rsp_valid_o, .rsp_ready_i, .rsp_rdata_o,
    .retire_o (retire), .retire_from_miss_o (retire_from_miss)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_llc -o tb_llc_sim; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_llc_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" <<< "$output"; then
  exit 0
fi
exit 1

//--- tb_llc.sv
/*
 * testbench for the cache with a memory model that stalls at random
 * the shadow model advances on each response, so responses must come in request order
 */
`timescale 1ns/1ps
`default_nettype none

module tb_llc;
  import llc_pkg::*;

  localparam int unsigned MemWords     = 2 ** (AddrWidth - ByteOffsetLength);
  localparam int unsigned NumReqs      = 307;
  localparam int unsigned CyclesPerReq = 40;   // miss with dirty eviction and stalls
  localparam int unsigned MaxCycles    = 2 * (16 + NumReqs * CyclesPerReq);
  localparam addr_t       LineMask     = addr_t'(NoBlocks * StrbWidth - 1);

  logic  clk, rst_n;
  logic  req_valid, req_ready, req_write, rsp_valid, rsp_ready;
  addr_t req_addr, mem_w_addr, mem_ar_addr, r_line;
  data_t req_wdata, rsp_rdata, mem_w_data, mem_r_data;
  strb_t req_strb;
  logic  mem_w_valid, mem_w_ready, mem_ar_valid, mem_ar_ready;
  logic  mem_r_valid, mem_r_ready, r_taken, rsp_stall_en;

  data_t       mem_model [MemWords];
  data_t       ref_mem   [MemWords];   // word contents as the requester sees them
  req_t        pend_q [$];
  tag_t        sh_tag   [NoLines][NoWays];
  logic        sh_valid [NoLines][NoWays];
  logic        sh_dirty [NoLines][NoWays];
  int unsigned sh_rr    [NoLines];
  int unsigned exp_misses, exp_evicts, ar_cnt, w_cnt, r_left, cycle_cnt;
  logic [31:0] stim_seed, stall_seed;

  llc_top UUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_write_i (req_write),
    .req_addr_i (req_addr), .req_wdata_i (req_wdata), .req_strb_i (req_strb),
    .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_rdata_o (rsp_rdata),
    .mem_w_valid_o (mem_w_valid), .mem_w_ready_i (mem_w_ready),
    .mem_w_addr_o (mem_w_addr), .mem_w_data_o (mem_w_data),
    .mem_ar_valid_o (mem_ar_valid), .mem_ar_ready_i (mem_ar_ready),
    .mem_ar_addr_o (mem_ar_addr),
    .mem_r_valid_i (mem_r_valid), .mem_r_ready_o (mem_r_ready), .mem_r_data_i (mem_r_data)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // odd multiplier keeps every word address distinct
  function automatic data_t init_word(input int unsigned w);
    return (w * 32'h9E37_79B1) ^ 32'h5A5A_0000;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t s);
    data_t r;
    r = old;
    for (int b = 0; b < StrbWidth; b++) begin
      if (s[b]) r[8*b +: 8] = nw[8*b +: 8];
    end
    return r;
  endfunction

  // line the shadow model evicts next when a misses
  function automatic addr_t victim_line(input addr_t a);
    index_t l;
    l = a[ByteOffsetLength+BlockOffsetLength +: IndexLength];
    return {sh_tag[l][sh_rr[l]], l, {(BlockOffsetLength + ByteOffsetLength){1'b0}}};
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input logic wr, input addr_t a, input data_t d, input strb_t s);
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = a;
    req_wdata = d;
    req_strb  = s;
    while (!req_ready) @(negedge clk);
    pend_q.push_back(req_t'{write: wr, addr: a, wdata: d, strb: s});
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (pend_q.size() != 0) @(negedge clk);
  endtask

  task automatic check_response();
    req_t        r;
    int unsigned w, line;
    int          way;
    tag_t        tag;
    assert (pend_q.size() != 0) else report_error("a response arrived with no request open");
    r    = pend_q.pop_front();
    w    = r.addr >> ByteOffsetLength;
    line = r.addr[ByteOffsetLength+BlockOffsetLength +: IndexLength];
    tag  = r.addr[AddrWidth-1 -: TagLength];
    way  = -1;
    for (int k = 0; k < NoWays; k++) begin
      if (sh_valid[line][k] && sh_tag[line][k] == tag) way = k;
    end
    if (way < 0) begin   // miss, round robin victim
      exp_misses++;
      if (sh_valid[line][sh_rr[line]] && sh_dirty[line][sh_rr[line]]) exp_evicts++;
      sh_tag[line][sh_rr[line]]   = tag;
      sh_valid[line][sh_rr[line]] = 1'b1;
      sh_dirty[line][sh_rr[line]] = r.write;
      sh_rr[line] = (sh_rr[line] + 1) % NoWays;
    end else if (r.write) begin
      sh_dirty[line][way] = 1'b1;
    end
    assert (ar_cnt == exp_misses) else report_error($sformatf(
      "mismatch at %0t: %0d line reads, expected %0d", $time, ar_cnt, exp_misses));
    assert (w_cnt == NoBlocks * exp_evicts) else report_error($sformatf(
      "mismatch at %0t: %0d write-back words, expected %0d", $time, w_cnt,
      NoBlocks * exp_evicts));
    if (r.write) begin
      assert (rsp_rdata == '0) else report_error($sformatf(
        "mismatch at %0t: write to %h answered %h, expected zero", $time, r.addr, rsp_rdata));
      ref_mem[w] = merge_bytes(ref_mem[w], r.wdata, r.strb);
    end else begin
      assert (rsp_rdata == ref_mem[w]) else report_error($sformatf(
        "mismatch at %0t: read of %h returned %h, expected %h", $time, r.addr, rsp_rdata,
        ref_mem[w]));
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && rsp_valid && rsp_ready) check_response();
  end

  // write-back words must hold the current contents of the victim line
  always @(posedge clk) begin
    if (rst_n && mem_w_valid && mem_w_ready) begin
      assert (pend_q.size() != 0 && (mem_w_addr & ~LineMask) == victim_line(pend_q[0].addr))
        else report_error($sformatf("mismatch at %0t: write-back to %h, expected line %h",
        $time, mem_w_addr, victim_line(pend_q[0].addr)));
      assert (mem_w_data == ref_mem[mem_w_addr >> ByteOffsetLength]) else report_error(
        $sformatf("mismatch at %0t: write-back of %h carried %h, expected %h", $time,
        mem_w_addr, mem_w_data, ref_mem[mem_w_addr >> ByteOffsetLength]));
      mem_model[mem_w_addr >> ByteOffsetLength] = mem_w_data;
      w_cnt <= w_cnt + 1;
    end
  end

  always @(posedge clk) begin
    if (rst_n && mem_ar_valid && mem_ar_ready) begin
      assert (r_left == 0) else report_error("a line read was issued during a refill");
      assert (pend_q.size() != 0 && mem_ar_addr == (pend_q[0].addr & ~LineMask))
        else report_error($sformatf("mismatch at %0t: line read of %h, expected %h", $time,
        mem_ar_addr, pend_q[0].addr & ~LineMask));
      r_line <= mem_ar_addr;
      r_left <= NoBlocks;
      ar_cnt <= ar_cnt + 1;
    end
    r_taken <= mem_r_valid && mem_r_ready;
    if (mem_r_valid && mem_r_ready) r_left <= r_left - 1;
  end

  always @(negedge clk) begin   // memory and response stalls
    stall_seed   = lcg_step(stall_seed);
    mem_w_ready  = stall_seed[28];
    mem_ar_ready = stall_seed[29];
    rsp_ready    = !rsp_stall_en || stall_seed[30] || stall_seed[27];
    if (!mem_r_valid || r_taken) begin
      mem_r_valid = (r_left != 0) && stall_seed[31];
      if (r_left != 0) mem_r_data = mem_model[(r_line >> ByteOffsetLength) + NoBlocks - r_left];
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout: the run went past %0d cycles without finishing", MaxCycles);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [31:0] ctl;
    clk          = 1'b0;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_write    = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    req_strb     = '0;
    rsp_ready    = 1'b1;
    mem_w_ready  = 1'b0;
    mem_ar_ready = 1'b0;
    mem_r_valid  = 1'b0;
    mem_r_data   = '0;
    stim_seed    = 32'd71;
    stall_seed   = lcg_step(32'd71);
    rsp_stall_en = 1'b0;
    r_line       = '0;
    r_left       = 0;
    r_taken      = 1'b0;
    ar_cnt       = 0;
    w_cnt        = 0;
    cycle_cnt    = 0;
    exp_misses   = 0;
    exp_evicts   = 0;
    for (int unsigned w = 0; w < MemWords; w++) begin
      mem_model[w] = init_word(w);
      ref_mem[w]   = init_word(w);
    end
    for (int l = 0; l < NoLines; l++) begin
      sh_rr[l] = 0;
      for (int k = 0; k < NoWays; k++) begin
        sh_valid[l][k] = 1'b0;
        sh_dirty[l][k] = 1'b0;
        sh_tag[l][k]   = '0;
      end
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!rsp_valid && !mem_w_valid && !mem_ar_valid && !mem_r_ready)
      else report_error("a response or memory valid was high right after reset");

    // cold read, then a strobed write and read back of the same word
    send_req(1'b0, 16'h0124, '0, '0);
    send_req(1'b1, 16'h0124, 32'hDEAD_BEEF, 4'b0101);
    send_req(1'b0, 16'h0124, '0, '0);
    wait_idle();

    // three tags on index 5, two dirty victims get written back
    send_req(1'b1, {8'h11, 4'h5, 2'd1, 2'd0}, 32'h1111_2222, 4'hF);
    send_req(1'b1, {8'h22, 4'h5, 2'd2, 2'd0}, 32'h3333_4444, 4'hC);
    send_req(1'b0, {8'h33, 4'h5, 2'd0, 2'd0}, '0, '0);
    send_req(1'b0, {8'h11, 4'h5, 2'd1, 2'd0}, '0, '0);
    wait_idle();
    assert (w_cnt == 2 * NoBlocks) else report_error($sformatf(
      "mismatch at %0t: %0d write-back words after the conflicts, expected %0d", $time,
      w_cnt, 2 * NoBlocks));

    rsp_stall_en = 1'b1;
    repeat (300) begin
      stim_seed = lcg_step(stim_seed);
      ctl       = stim_seed;
      stim_seed = lcg_step(stim_seed);
      send_req(ctl[31], {tag_t'(ctl[30:29]) << 3, index_t'(ctl[28:27]), ctl[26:25], 2'd0},
               stim_seed, ctl[24:21]);
    end
    wait_idle();
    assert (r_left == 0 && !mem_w_valid && !mem_ar_valid)
      else report_error("memory traffic was still open after the last response");
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
